//--- rtl/upd_periph_pkg.sv
/* uPD7800 peripheral definitions
   Register selects, interrupt sources, vectors and bus structs */

package upd_periph_pkg;

  typedef logic [7:0] byte_t;

  // Special register codes as used by the MOV sr instructions
  typedef enum logic [2:0] {
    SPR_PA  = 3'd0,
    SPR_PB  = 3'd1,
    SPR_PC  = 3'd2,
    SPR_MK  = 3'd3,
    SPR_MB  = 3'd4,
    SPR_MC  = 3'd5,
    SPR_TM0 = 3'd6,
    SPR_TM1 = 3'd7
  } spr_sel_t;

  typedef struct packed {
    logic     strobe;
    spr_sel_t sel;
    byte_t    data;
  } spr_wr_t;

  // TM1[3:0] over TM0
  typedef logic [11:0] tm_reload_t;

  ////////////////////
  // Interrupts

  // One bit per source, lower index wins
  typedef logic [3:0] int_src_t;

  localparam int INT_IDX_INT0 = 0;
  localparam int INT_IDX_INTT = 1;
  localparam int INT_IDX_INT1 = 2;
  localparam int INT_IDX_INT2 = 3;

  typedef logic [7:0] int_vec_t;

  localparam int_vec_t VEC_INT0 = 8'h04;
  localparam int_vec_t VEC_INTT = 8'h08;
  localparam int_vec_t VEC_INT1 = 8'h10;
  localparam int_vec_t VEC_INT2 = 8'h20;
  localparam int_vec_t VEC_NONE = 8'h00;

  typedef struct packed {
    byte_t out;
    byte_t oe;
  } port_pins_t;

  localparam byte_t      MK_RESET   = 8'hff;
  localparam byte_t      MODE_RESET = 8'hff;
  localparam tm_reload_t TM_RESET   = 12'hfff;

  // MK[3:0] mask sources in int_src_t order
  localparam int MK_BIT_INT2_POL = 5;

endpackage

//--- rtl/upd_spr_ports.sv
/* Special register file with port direction, Port C control-bit masking
   and register readback */

`timescale 1ns/1ns

module upd_spr_ports (
  input  logic                       CLK,
  input  logic                       reset,
  input  upd_periph_pkg::spr_wr_t    spr_wr,
  input  upd_periph_pkg::spr_sel_t   spr_rd_sel,
  input  upd_periph_pkg::byte_t      pb_in,
  input  upd_periph_pkg::byte_t      pc_in,
  output upd_periph_pkg::byte_t      spr_rdata,
  output upd_periph_pkg::byte_t      pa_out,
  output upd_periph_pkg::port_pins_t pb,
  output upd_periph_pkg::port_pins_t pc,
  output upd_periph_pkg::byte_t      mk,
  output upd_periph_pkg::tm_reload_t tm_reload
);

  upd_periph_pkg::byte_t      pa_latch;
  upd_periph_pkg::byte_t      pb_latch;
  upd_periph_pkg::byte_t      pc_latch;
  upd_periph_pkg::byte_t      mb;
  upd_periph_pkg::byte_t      mc;
  upd_periph_pkg::tm_reload_t tm;
  upd_periph_pkg::byte_t      pb_merged;
  upd_periph_pkg::byte_t      pc_merged;

  ////////////////////
  // Register writes

  always_ff @(posedge CLK) begin
    if (reset) begin
      pa_latch <= '0;
      pb_latch <= '0;
      pc_latch <= '0;
      mk       <= upd_periph_pkg::MK_RESET;
      mb       <= upd_periph_pkg::MODE_RESET;
      mc       <= upd_periph_pkg::MODE_RESET;
      tm       <= upd_periph_pkg::TM_RESET;
    end else if (spr_wr.strobe) begin
      case (spr_wr.sel)
        upd_periph_pkg::SPR_PA:  pa_latch <= spr_wr.data;
        upd_periph_pkg::SPR_PB:  pb_latch <= spr_wr.data;
        upd_periph_pkg::SPR_PC:  pc_latch <= spr_wr.data;
        upd_periph_pkg::SPR_MK:  mk <= spr_wr.data;
        upd_periph_pkg::SPR_MB:  mb <= spr_wr.data;
        upd_periph_pkg::SPR_MC:  mc <= spr_wr.data;
        upd_periph_pkg::SPR_TM0: tm[7:0] <= spr_wr.data;
        upd_periph_pkg::SPR_TM1: tm[11:8] <= spr_wr.data[3:0];
        default: ;
      endcase
    end
  end

  ////////////////////
  // Port pins

  // Mode bit set means input
  assign pb.oe  = ~mb;
  assign pb.out = pb_latch;

  // PC6..PC3 are always outputs, PC2 always input
  assign pc.oe  = {~mc[7], 4'b1111, 1'b0, ~mc[1:0]};
  // Control-function bits hold their port output low
  assign pc.out = pc_latch & {mc[7:2], ~mc[1:0]};

  assign pa_out = pa_latch;

  // Output bits read back the latch, inputs read the pin
  assign pb_merged = (pb_latch & pb.oe) | (pb_in & ~pb.oe);
  assign pc_merged = (pc_latch & pc.oe) | (pc_in & ~pc.oe);

  ////////////////////
  // Readback

  always_comb begin
    spr_rdata = '0;
    case (spr_rd_sel)
      upd_periph_pkg::SPR_PA:  spr_rdata = pa_latch;
      upd_periph_pkg::SPR_PB:  spr_rdata = pb_merged;
      upd_periph_pkg::SPR_PC:  spr_rdata = pc_merged;
      upd_periph_pkg::SPR_MK:  spr_rdata = mk;
      upd_periph_pkg::SPR_MB:  spr_rdata = mb;
      upd_periph_pkg::SPR_MC:  spr_rdata = mc;
      upd_periph_pkg::SPR_TM0: spr_rdata = tm[7:0];
      upd_periph_pkg::SPR_TM1: spr_rdata = {4'b0000, tm[11:8]};
      default: ;
    endcase
  end

  assign tm_reload = tm;

endmodule

//--- rtl/upd_timer.sv
/* Interval timer, a 12-bit down counter behind a prescaler
   with reload on underflow or timer start */

`timescale 1ns/1ns

module upd_timer #(
  parameter int PRESCALE_BITS = 3
) (
  input  logic                       CLK,
  input  logic                       reset,
  input  upd_periph_pkg::tm_reload_t tm_reload,
  input  logic                       tm_start,
  output logic                       tm_underflow
);

  localparam int CNT_W = $bits(upd_periph_pkg::tm_reload_t) + PRESCALE_BITS;

  // Counter bits above, prescaler bits below
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] reload_value;

  // Prescaler restarts from all ones on every reload
  assign reload_value = {tm_reload, {PRESCALE_BITS{1'b1}}};

  // High for the one cycle the count sits at zero
  assign tm_underflow = (count == '0);

  always_ff @(posedge CLK) begin
    if (reset) begin
      count <= {upd_periph_pkg::TM_RESET, {PRESCALE_BITS{1'b1}}};
    end else if (tm_underflow || tm_start) begin
      count <= reload_value;
    end else begin
      count <= count - CNT_W'(1);
    end
  end

endmodule

//--- rtl/upd_int_sampler.sv
/* INT1/INT2 sampling at the divided strobe
   Edge qualified by one low sample then three high ones */

`timescale 1ns/1ns

module upd_int_sampler #(
  parameter int SAMPLE_DIV = 12
) (
  input  logic CLK,
  input  logic reset,
  input  logic int1,
  input  logic int2,
  input  logic int2_active_high,
  output logic int1_edge,
  output logic int2_edge
);

  localparam int DIV_W = $clog2(SAMPLE_DIV);

  logic [DIV_W-1:0] div_cnt;
  logic             strobe;
  logic [1:0]       sample;
  logic [3:0]       hist [2];
  logic [1:0]       qualified;

  ////////////////////
  // Sample strobe

  assign strobe = (div_cnt == DIV_W'(SAMPLE_DIV - 1));

  always_ff @(posedge CLK) begin
    if (reset) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= strobe ? '0 : div_cnt + 1'b1;
    end
  end

  ////////////////////
  // Filters

  // Active-low INT2 is turned into a rising request
  assign sample = {int2 ^ ~int2_active_high, int1};

  always_ff @(posedge CLK) begin
    if (reset) begin
      hist[0] <= '0;
      hist[1] <= '0;
    end else if (strobe) begin
      for (int i = 0; i < 2; i++) begin
        hist[i] <= {hist[i][2:0], sample[i]};
      end
    end
  end

  // Oldest sample low, newest three high
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      qualified[i] = strobe && (hist[i] == 4'b0111);
    end
  end

  assign int1_edge = qualified[0];
  assign int2_edge = qualified[1];

endmodule

//--- rtl/upd_int_ctrl.sv
/* Interrupt controller with pending flags, MK/IE masking,
   fixed priority and vector output */

`timescale 1ns/1ns

module upd_int_ctrl (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic                     int0,
  input  logic                     int1_edge,
  input  logic                     int2_edge,
  input  logic                     tm_underflow,
  input  upd_periph_pkg::byte_t    mk,
  input  logic                     int_enable,
  input  logic                     int_ack,
  output logic                     irq,
  output upd_periph_pkg::int_vec_t int_vector
);

  upd_periph_pkg::int_src_t pending;
  upd_periph_pkg::int_src_t req_set;
  upd_periph_pkg::int_src_t req_clr;
  upd_periph_pkg::int_src_t enabled;
  upd_periph_pkg::int_src_t active;
  upd_periph_pkg::int_src_t winner;

  ////////////////////
  // Pending flags

  always_comb begin
    req_set = '0;
    // INT0 is a level, re-pended while held high
    req_set[upd_periph_pkg::INT_IDX_INT0] = int0 & ~pending[upd_periph_pkg::INT_IDX_INT0];
    req_set[upd_periph_pkg::INT_IDX_INTT] = tm_underflow;
    req_set[upd_periph_pkg::INT_IDX_INT1] = int1_edge;
    req_set[upd_periph_pkg::INT_IDX_INT2] = int2_edge;
  end

  always_comb begin
    req_clr = int_ack ? winner : '0;
    if (!int0) begin
      req_clr[upd_periph_pkg::INT_IDX_INT0] = 1'b1;
    end
  end

  // A new request on the acknowledge edge stays pending
  always_ff @(posedge CLK) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~req_clr) | req_set;
    end
  end

  ////////////////////
  // Mask and priority

  // MK bit set masks the source
  assign enabled = {4{int_enable}} & ~mk[3:0];
  assign active  = pending & enabled;

  // Lowest set bit has the highest priority
  assign winner = active & (~active + 1'b1);
  assign irq    = |active;

  always_comb begin
    int_vector = upd_periph_pkg::VEC_NONE;
    if (winner[upd_periph_pkg::INT_IDX_INT0]) begin
      int_vector = upd_periph_pkg::VEC_INT0;
    end else if (winner[upd_periph_pkg::INT_IDX_INTT]) begin
      int_vector = upd_periph_pkg::VEC_INTT;
    end else if (winner[upd_periph_pkg::INT_IDX_INT1]) begin
      int_vector = upd_periph_pkg::VEC_INT1;
    end else if (winner[upd_periph_pkg::INT_IDX_INT2]) begin
      int_vector = upd_periph_pkg::VEC_INT2;
    end
  end

endmodule

//--- rtl/upd_periph.sv
/* uPD7800 peripheral block with special registers, ports,
   interval timer and interrupt controller */

`timescale 1ns/1ns

module upd_periph #(
  parameter int SAMPLE_DIV    = 12,
  parameter int PRESCALE_BITS = 3
) (
  input  logic                       CLK,
  input  logic                       reset,
  input  upd_periph_pkg::spr_wr_t    spr_wr,
  input  upd_periph_pkg::spr_sel_t   spr_rd_sel,
  input  upd_periph_pkg::byte_t      pb_in,
  input  upd_periph_pkg::byte_t      pc_in,
  input  logic                       int0,
  input  logic                       int1,
  input  logic                       int2,
  input  logic                       int_enable,
  input  logic                       int_ack,
  input  logic                       tm_start,
  output upd_periph_pkg::byte_t      spr_rdata,
  output upd_periph_pkg::byte_t      pa_out,
  output upd_periph_pkg::port_pins_t pb,
  output upd_periph_pkg::port_pins_t pc,
  output logic                       irq,
  output upd_periph_pkg::int_vec_t   int_vector
);

  upd_periph_pkg::byte_t      mk;
  upd_periph_pkg::tm_reload_t tm_reload;
  logic                       tm_underflow;
  logic                       int1_edge;
  logic                       int2_edge;

  upd_spr_ports i_spr_ports (
    .CLK        (CLK),
    .reset      (reset),
    .spr_wr     (spr_wr),
    .spr_rd_sel (spr_rd_sel),
    .pb_in      (pb_in),
    .pc_in      (pc_in),
    .spr_rdata  (spr_rdata),
    .pa_out     (pa_out),
    .pb         (pb),
    .pc         (pc),
    .mk         (mk),
    .tm_reload  (tm_reload)
  );

  upd_timer #(
    .PRESCALE_BITS (PRESCALE_BITS)
  ) i_timer (
    .CLK          (CLK),
    .reset        (reset),
    .tm_reload    (tm_reload),
    .tm_start     (tm_start),
    .tm_underflow (tm_underflow)
  );

  // MK5 selects INT2 polarity
  upd_int_sampler #(
    .SAMPLE_DIV (SAMPLE_DIV)
  ) i_int_sampler (
    .CLK              (CLK),
    .reset            (reset),
    .int1             (int1),
    .int2             (int2),
    .int2_active_high (mk[upd_periph_pkg::MK_BIT_INT2_POL]),
    .int1_edge        (int1_edge),
    .int2_edge        (int2_edge)
  );

  upd_int_ctrl i_int_ctrl (
    .CLK          (CLK),
    .reset        (reset),
    .int0         (int0),
    .int1_edge    (int1_edge),
    .int2_edge    (int2_edge),
    .tm_underflow (tm_underflow),
    .mk           (mk),
    .int_enable   (int_enable),
    .int_ack      (int_ack),
    .irq          (irq),
    .int_vector   (int_vector)
  );

endmodule

//--- sim/upd_periph_assertions.sv
/* Interrupt controller properties, bound into upd_int_ctrl */

`timescale 1ns/1ns

module upd_periph_assertions (
  input logic                     CLK,
  input logic                     reset,
  input logic                     int0,
  input logic                     int1_edge,
  input logic                     int2_edge,
  input logic                     tm_underflow,
  input logic                     int_enable,
  input logic                     int_ack,
  input logic                     irq,
  input upd_periph_pkg::int_vec_t int_vector
);

  logic req_again;

  // Request of the source that currently wins
  always_comb begin
    case (int_vector)
      upd_periph_pkg::VEC_INT0: req_again = int0;
      upd_periph_pkg::VEC_INTT: req_again = tm_underflow;
      upd_periph_pkg::VEC_INT1: req_again = int1_edge;
      upd_periph_pkg::VEC_INT2: req_again = int2_edge;
      default:                  req_again = 1'b0;
    endcase
  end

  vector_valid: assert property (@(posedge CLK) disable iff (reset)
    irq |-> (int_vector == upd_periph_pkg::VEC_INT0 || int_vector == upd_periph_pkg::VEC_INTT ||
             int_vector == upd_periph_pkg::VEC_INT1 || int_vector == upd_periph_pkg::VEC_INT2))
    else $error("irq high with an unknown vector");

  irq_needs_enable: assert property (@(posedge CLK) disable iff (reset)
    !int_enable |-> !irq)
    else $error("irq high while interrupts are disabled");

  ack_clears: assert property (@(posedge CLK) disable iff (reset)
    (int_ack && irq && !req_again) |=> (int_vector != $past(int_vector)))
    else $error("acknowledged vector still served");

endmodule

bind upd_int_ctrl upd_periph_assertions i_assertions (
  .CLK          (CLK),
  .reset        (reset),
  .int0         (int0),
  .int1_edge    (int1_edge),
  .int2_edge    (int2_edge),
  .tm_underflow (tm_underflow),
  .int_enable   (int_enable),
  .int_ack      (int_ack),
  .irq          (irq),
  .int_vector   (int_vector)
);

//--- sim/upd_periph_tb.sv
/* Testbench for the uPD7800 peripheral block
   Seeded random stimulus checked against a register and interrupt model */

`timescale 1ns/1ns

module upd_periph_tb;

  localparam int SD              = 12;
  localparam int PRESCALE_BITS   = 3;
  localparam int CLK_PERIOD      = 100;
  // Worst-case cycles of each test section
  localparam int REG_CYCLES      = 16 + 8 * 2 + 40 * 4 + 20 * 12;
  localparam int TIMER_CYCLES    = 3 * (2 * 8 * 16 + 40);
  localparam int EDGE_CYCLES     = 2 * (4 * 6 * SD + 20 * SD);
  localparam int PRIO_CYCLES     = 16 * (40 + 8 * SD + 20) + 80;
  // Twice the sum as margin
  localparam int WATCHDOG_CYCLES = 2 * (REG_CYCLES + TIMER_CYCLES + EDGE_CYCLES + PRIO_CYCLES);

  logic                       CLK;
  logic                       reset;
  upd_periph_pkg::spr_wr_t    spr_wr;
  upd_periph_pkg::spr_sel_t   spr_rd_sel;
  upd_periph_pkg::byte_t      pb_in;
  upd_periph_pkg::byte_t      pc_in;
  logic                       int0;
  logic                       int1;
  logic                       int2;
  logic                       int_enable;
  logic                       int_ack;
  logic                       tm_start;
  upd_periph_pkg::byte_t      spr_rdata;
  upd_periph_pkg::byte_t      pa_out;
  upd_periph_pkg::port_pins_t pb;
  upd_periph_pkg::port_pins_t pc;
  logic                       irq;
  upd_periph_pkg::int_vec_t   int_vector;

  // Model of the eight special registers
  upd_periph_pkg::byte_t regs [8];

  upd_periph #(
    .SAMPLE_DIV    (SD),
    .PRESCALE_BITS (PRESCALE_BITS)
  ) i_upd_periph (
    .CLK        (CLK),
    .reset      (reset),
    .spr_wr     (spr_wr),
    .spr_rd_sel (spr_rd_sel),
    .pb_in      (pb_in),
    .pc_in      (pc_in),
    .int0       (int0),
    .int1       (int1),
    .int2       (int2),
    .int_enable (int_enable),
    .int_ack    (int_ack),
    .tm_start   (tm_start),
    .spr_rdata  (spr_rdata),
    .pa_out     (pa_out),
    .pb         (pb),
    .pc         (pc),
    .irq        (irq),
    .int_vector (int_vector)
  );

  initial CLK = 1'b0;
  always #(CLK_PERIOD / 2) CLK = ~CLK;

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Watchdog expired before the tests completed");
    $display("TEST FAILED");
    $fatal(1, "watchdog");
  end

  ////////////////////
  // Model

  function automatic upd_periph_pkg::byte_t pc_oe(upd_periph_pkg::byte_t mc);
    return {~mc[7], 4'b1111, 1'b0, ~mc[1:0]};
  endfunction

  function automatic upd_periph_pkg::byte_t read_model(upd_periph_pkg::spr_sel_t sel);
    upd_periph_pkg::byte_t oe;
    oe = pc_oe(regs[upd_periph_pkg::SPR_MC]);
    case (sel)
      upd_periph_pkg::SPR_PB:
        return (regs[1] & ~regs[upd_periph_pkg::SPR_MB]) | (pb_in & regs[upd_periph_pkg::SPR_MB]);
      upd_periph_pkg::SPR_PC: return (regs[2] & oe) | (pc_in & ~oe);
      default:                return regs[sel];
    endcase
  endfunction

  function automatic upd_periph_pkg::int_vec_t vec_of(upd_periph_pkg::int_src_t p);
    if (p[upd_periph_pkg::INT_IDX_INT0]) return upd_periph_pkg::VEC_INT0;
    if (p[upd_periph_pkg::INT_IDX_INTT]) return upd_periph_pkg::VEC_INTT;
    if (p[upd_periph_pkg::INT_IDX_INT1]) return upd_periph_pkg::VEC_INT1;
    if (p[upd_periph_pkg::INT_IDX_INT2]) return upd_periph_pkg::VEC_INT2;
    return upd_periph_pkg::VEC_NONE;
  endfunction

  // Source served next, index order is priority order
  function automatic upd_periph_pkg::int_src_t first_src(upd_periph_pkg::int_src_t p);
    for (int b = 0; b < 4; b++) begin
      if (p[b]) return upd_periph_pkg::int_src_t'(1 << b);
    end
    return '0;
  endfunction

  ////////////////////
  // Compare tasks

  task automatic check_byte(string name, upd_periph_pkg::byte_t exp, upd_periph_pkg::byte_t act);
    if (exp !== act) begin
      $display("ERR %s expected %02h actual %02h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "byte mismatch");
    end
  endtask

  task automatic check_pins(string name, upd_periph_pkg::port_pins_t exp,
                            upd_periph_pkg::port_pins_t act);
    if (exp !== act) begin
      $display("ERR %s expected %04h actual %04h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "pin mismatch");
    end
  endtask

  task automatic check_vector(string name, upd_periph_pkg::int_vec_t exp,
                              upd_periph_pkg::int_vec_t act);
    if (exp !== act) begin
      $display("ERR %s expected %02h actual %02h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "vector mismatch");
    end
  endtask

  task automatic check_irq(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("ERR %s expected %0b actual %0b", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "irq mismatch");
    end
  endtask

  ////////////////////
  // Bus and pin helpers

  task automatic write_reg(upd_periph_pkg::spr_sel_t sel, upd_periph_pkg::byte_t data);
    @(posedge CLK);
    spr_wr <= '{strobe: 1'b1, sel: sel, data: data};
    @(posedge CLK);
    spr_wr.strobe <= 1'b0;
    regs[sel] = (sel == upd_periph_pkg::SPR_TM1) ? (data & 8'h0f) : data;
  endtask

  task automatic read_check(string name, upd_periph_pkg::spr_sel_t sel);
    @(posedge CLK);
    spr_rd_sel <= sel;
    @(negedge CLK);
    check_byte(name, read_model(sel), spr_rdata);
  endtask

  task automatic pulse_ack(logic drop_int0);
    @(posedge CLK);
    int_ack <= 1'b1;
    if (drop_int0) int0 <= 1'b0;
    @(posedge CLK);
    int_ack <= 1'b0;
  endtask

  task automatic pulse_tm_start();
    @(posedge CLK);
    tm_start <= 1'b1;
    @(posedge CLK);
    tm_start <= 1'b0;
  endtask

  // Acknowledge whatever is left pending and unmasked
  task automatic drain();
    repeat (6) begin
      @(negedge CLK);
      if (irq) pulse_ack(1'b0);
    end
  endtask

  // irq low for n-1 edges, high after edge n
  task automatic irq_after(string name, int n);
    for (int k = 1; k <= n; k++) begin
      @(posedge CLK);
      @(negedge CLK);
      check_irq(name, k == n, irq);
    end
  endtask

  task automatic quiet(string name, int cycles);
    repeat (cycles) begin
      @(negedge CLK);
      check_irq(name, 1'b0, irq);
    end
  endtask

  task automatic wait_irq(string name, int max);
    int k;
    k = 0;
    @(negedge CLK);
    while (!irq && k < max) begin
      @(negedge CLK);
      k++;
    end
    check_irq(name, 1'b1, irq);
  endtask

  ////////////////////
  // Tests

  initial begin
    upd_periph_pkg::spr_sel_t   sel;
    upd_periph_pkg::port_pins_t exp_pins;
    upd_periph_pkg::int_src_t   pend;
    upd_periph_pkg::int_src_t   win;
    logic [3:0]                 mask;
    logic                       ie;
    int                         r;
    int                         n;
    int                         len;

    void'($urandom(32'h19d2));
    reset      = 1'b1;
    spr_wr     = '0;
    spr_rd_sel = upd_periph_pkg::SPR_PA;
    pb_in      = '0;
    pc_in      = '0;
    int0       = 1'b0;
    int1       = 1'b0;
    int2       = 1'b0;
    int_enable = 1'b0;
    int_ack    = 1'b0;
    tm_start   = 1'b0;
    regs = '{8'h00, 8'h00, 8'h00, 8'hff, 8'hff, 8'hff, 8'hff, 8'h0f};
    repeat (16) @(posedge CLK);
    reset <= 1'b0;

    // Reset values, then random writes with readback
    for (int i = 0; i < 8; i++) read_check("reset readback", upd_periph_pkg::spr_sel_t'(i));
    for (int i = 0; i < 40; i++) begin
      sel = upd_periph_pkg::spr_sel_t'($urandom_range(7, 0));
      write_reg(sel, $urandom);
      read_check("register readback", sel);
    end

    // Port direction, masking and merged readback
    for (int i = 0; i < 20; i++) begin
      write_reg(upd_periph_pkg::SPR_MB, $urandom);
      write_reg(upd_periph_pkg::SPR_MC, $urandom);
      write_reg(upd_periph_pkg::SPR_PB, $urandom);
      write_reg(upd_periph_pkg::SPR_PC, $urandom);
      @(posedge CLK);
      pb_in <= $urandom;
      pc_in <= $urandom;
      @(negedge CLK);
      exp_pins.out = regs[1];
      exp_pins.oe  = ~regs[upd_periph_pkg::SPR_MB];
      check_pins("port b pins", exp_pins, pb);
      exp_pins.oe  = pc_oe(regs[upd_periph_pkg::SPR_MC]);
      exp_pins.out = regs[2] & {regs[5][7:2], ~regs[5][1:0]};
      check_pins("port c pins", exp_pins, pc);
      check_byte("port a pins", regs[0], pa_out);
      read_check("port b readback", upd_periph_pkg::SPR_PB);
      read_check("port c readback", upd_periph_pkg::SPR_PC);
    end

    // Timer period with only INTT unmasked
    write_reg(upd_periph_pkg::SPR_MK, 8'hfd);
    @(posedge CLK);
    int_enable <= 1'b1;
    for (int i = 0; i < 3; i++) begin
      r = 1 + $urandom % 15;
      n = 8 * (r + 1);
      write_reg(upd_periph_pkg::SPR_TM0, 8'hff);
      write_reg(upd_periph_pkg::SPR_TM1, 8'h0f);
      pulse_tm_start();
      drain();
      write_reg(upd_periph_pkg::SPR_TM0, upd_periph_pkg::byte_t'(r));
      write_reg(upd_periph_pkg::SPR_TM1, 8'h00);
      pulse_tm_start();
      irq_after("timer first period", n);
      check_vector("timer vector", upd_periph_pkg::VEC_INTT, int_vector);
      pulse_ack(1'b0);
      irq_after("timer second period", n - 2);
      pulse_ack(1'b0);
    end

    // INT1 glitches and a held level
    write_reg(upd_periph_pkg::SPR_MK, 8'hfb);
    for (int g = 0; g < 4; g++) begin
      len = 1 + $urandom % (SD - 1);
      @(posedge CLK);
      int1 <= 1'b1;
      repeat (len) @(posedge CLK);
      int1 <= 1'b0;
      quiet("int1 glitch", 5 * SD);
    end
    @(posedge CLK);
    int1 <= 1'b1;
    wait_irq("int1 level", 5 * SD);
    check_vector("int1 vector", upd_periph_pkg::VEC_INT1, int_vector);
    repeat (5 * SD) @(posedge CLK);
    int1 <= 1'b0;
    pulse_ack(1'b0);
    quiet("int1 after ack", 2 * SD);

    // INT2 active low with MK bit 5 clear
    write_reg(upd_periph_pkg::SPR_MK, 8'hff);
    @(posedge CLK);
    int2 <= 1'b1;
    repeat (5 * SD) @(posedge CLK);
    write_reg(upd_periph_pkg::SPR_MK, 8'hd7);
    repeat (3 * SD) @(posedge CLK);
    drain();
    for (int g = 0; g < 4; g++) begin
      len = 1 + $urandom % (SD - 1);
      @(posedge CLK);
      int2 <= 1'b0;
      repeat (len) @(posedge CLK);
      int2 <= 1'b1;
      quiet("int2 glitch", 5 * SD);
    end
    @(posedge CLK);
    int2 <= 1'b0;
    wait_irq("int2 falling level", 5 * SD);
    check_vector("int2 vector", upd_periph_pkg::VEC_INT2, int_vector);
    pulse_ack(1'b0);
    quiet("int2 after ack", 2 * SD);

    // Priority, masking and acknowledge
    write_reg(upd_periph_pkg::SPR_TM0, 8'hff);
    write_reg(upd_periph_pkg::SPR_TM1, 8'h0f);
    pulse_tm_start();
    // Clear timer requests left from the earlier sections, INT2 back to active high
    write_reg(upd_periph_pkg::SPR_MK, 8'h20);
    repeat (3 * SD) @(posedge CLK);
    drain();
    for (int i = 0; i < 16; i++) begin
      pend = $urandom;
      mask = $urandom;
      ie   = $urandom;
      @(posedge CLK);
      int_enable <= 1'b0;
      write_reg(upd_periph_pkg::SPR_MK, 8'h2f);
      if (pend[upd_periph_pkg::INT_IDX_INTT]) begin
        write_reg(upd_periph_pkg::SPR_TM0, 8'h00);
        write_reg(upd_periph_pkg::SPR_TM1, 8'h00);
        pulse_tm_start();
        repeat (10) @(posedge CLK);
        write_reg(upd_periph_pkg::SPR_TM0, 8'hff);
        write_reg(upd_periph_pkg::SPR_TM1, 8'h0f);
      end
      pulse_tm_start();
      @(posedge CLK);
      int0 <= pend[upd_periph_pkg::INT_IDX_INT0];
      int1 <= pend[upd_periph_pkg::INT_IDX_INT1];
      int2 <= pend[upd_periph_pkg::INT_IDX_INT2];
      repeat (5 * SD) @(posedge CLK);
      int1 <= 1'b0;
      int2 <= 1'b0;
      repeat (2 * SD) @(posedge CLK);
      write_reg(upd_periph_pkg::SPR_MK, {4'h2, mask});
      @(posedge CLK);
      int_enable <= ie;
      @(negedge CLK);
      check_irq("masked irq", ie && |(pend & ~mask), irq);
      if (ie && |(pend & ~mask)) begin
        check_vector("masked vector", vec_of(pend & ~mask), int_vector);
      end
      write_reg(upd_periph_pkg::SPR_MK, 8'h20);
      @(posedge CLK);
      int_enable <= 1'b1;
      while (pend != '0) begin
        @(negedge CLK);
        check_irq("priority irq", 1'b1, irq);
        check_vector("priority vector", vec_of(pend), int_vector);
        win = first_src(pend);
        pulse_ack(win[upd_periph_pkg::INT_IDX_INT0]);
        pend = pend & ~win;
      end
      @(negedge CLK);
      check_irq("all served", 1'b0, irq);
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- upd_periph.f
rtl/upd_periph_pkg.sv
rtl/upd_spr_ports.sv
rtl/upd_timer.sv
rtl/upd_int_sampler.sv
rtl/upd_int_ctrl.sv
rtl/upd_periph.sv
sim/upd_periph_assertions.sv
sim/upd_periph_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module upd_periph_tb \
  -f upd_periph.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vupd_periph_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "TEST PASSED"; then
  exit 0
fi
exit 1
